// ==== hw/nabp_pkg.sv ====
package nabp_pkg;

    // angle coding
    localparam int angle_length = 4;
    localparam logic [angle_length-1:0] angle_step = angle_length'(1);
    // 180 degrees, so angles run 0 to half_turn - angle_step
    localparam logic [angle_length-1:0] half_turn = angle_length'(8);

    // detector index along one projection line
    localparam int s_length = 4;
    localparam int projection_line_size = 16;

    // sinogram store geometry
    localparam int sinogram_address_length = 7;
    localparam int sinogram_words = 1 << sinogram_address_length;

    // sample widths, stored unsigned and filtered signed
    localparam int sample_width = 12;
    localparam int filt_width = sample_width + 1;

    // one stored sample tagged with its position in the sinogram
    typedef struct packed {
        logic [angle_length-1:0] angle;
        logic [s_length-1:0]     s;
        // final detector index of the line
        logic                    last;
        logic [sample_width-1:0] data;
    } line_sample_t;

    // filtered output sample
    typedef struct packed {
        logic [angle_length-1:0]      angle;
        logic [s_length-1:0]          s;
        logic signed [filt_width-1:0] value;
    } filt_sample_t;

endpackage

// ==== hw/nabp_sinogram_top.sv ====
`timescale 1ns/1ps

module nabp_sinogram_top
    import nabp_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset_n,
    // host load port
    input  logic                               wr_en,
    input  logic [sinogram_address_length-1:0] wr_addr,
    input  logic [sample_width-1:0]            wr_data,
    // host control
    input  logic                               hs_kick,
    output logic                               hs_done,
    output logic                               fr_busy,
    // filtered stream
    output filt_sample_t                       filt_sample,
    output logic                               filt_valid
);

    logic [s_length-1:0]                fr_s_val;
    logic                               fr_next_angle;
    logic [angle_length-1:0]            fr_angle;
    logic [sinogram_address_length-1:0] sg_addr;
    logic [sample_width-1:0]            rd_data;
    line_sample_t                       line_sample;
    logic                               line_valid;

    sinogram_addresser u_addresser (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_kick           (hs_kick),
        .fr_s_val          (fr_s_val),
        .fr_next_angle     (fr_next_angle),
        .hs_done           (hs_done),
        .fr_busy           (fr_busy),
        .fr_angle          (fr_angle),
        .fr_has_next_angle (),
        .fr_next_angle_ack (),
        .sg_addr           (sg_addr)
    );

    sinogram_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (sg_addr),
        .rd_data (rd_data)
    );

    projection_line_reader u_reader (
        .clk           (clk),
        .reset_n       (reset_n),
        .fr_busy       (fr_busy),
        .fr_angle      (fr_angle),
        .rd_data       (rd_data),
        .fr_s_val      (fr_s_val),
        .fr_next_angle (fr_next_angle),
        .line_sample   (line_sample),
        .line_valid    (line_valid)
    );

    ramp_filter u_filter (
        .clk         (clk),
        .reset_n     (reset_n),
        .line_sample (line_sample),
        .line_valid  (line_valid),
        .filt_sample (filt_sample),
        .filt_valid  (filt_valid)
    );

endmodule

// ==== hw/projection_line_reader.sv ====
`timescale 1ns/1ps

module projection_line_reader
    import nabp_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    // from the addresser
    input  logic                    fr_busy,
    input  logic [angle_length-1:0] fr_angle,
    // from the sinogram RAM
    input  logic [sample_width-1:0] rd_data,
    // to the addresser
    output logic [s_length-1:0]     fr_s_val,
    output logic                    fr_next_angle,
    // to the filter
    output line_sample_t            line_sample,
    output logic                    line_valid
);

    localparam logic [s_length-1:0] s_last = s_length'(projection_line_size - 1);

    logic [s_length-1:0] s_cnt;
    logic                line_end;

    // tags of the address cycle, waiting for RAM data
    logic                    tag_valid;
    logic [angle_length-1:0] tag_angle;
    logic [s_length-1:0]     tag_s;
    logic                    tag_last;

    assign line_end = (s_cnt == s_last);

    assign fr_s_val = s_cnt;
    assign fr_next_angle = fr_busy && line_end;

    // detector index, wraps into the next line without a gap
    always_ff @(posedge clk)
    begin
        if (reset_n || !fr_busy)
        begin
            s_cnt <= '0;
        end
        else
        begin
            s_cnt <= s_cnt + s_length'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            tag_valid <= 1'b0;
        end
        else
        begin
            tag_valid <= fr_busy;
        end
    end

    // payload tags
    always_ff @(posedge clk)
    begin
        tag_angle <= fr_angle;
        tag_s     <= s_cnt;
        tag_last  <= line_end;
    end

    // join the tags with the sample read back this cycle
    always_comb
    begin
        line_sample.angle = tag_angle;
        line_sample.s     = tag_s;
        line_sample.last  = tag_last;
        line_sample.data  = rd_data;
    end

    assign line_valid = tag_valid;

endmodule

// ==== hw/ramp_filter.sv ====
`timescale 1ns/1ps

module ramp_filter
    import nabp_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    // tagged samples from the line reader
    input  line_sample_t line_sample,
    input  logic         line_valid,
    // filtered output
    output filt_sample_t filt_sample,
    output logic         filt_valid
);

    logic [sample_width-1:0]      prev_data;
    logic                         prev_last;
    logic signed [filt_width-1:0] diff;

    // both operands zero extended, so the difference fits one extra bit
    assign diff = $signed({1'b0, line_sample.data}) - $signed({1'b0, prev_data});

    // previous sample, zero at the head of each line
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            prev_data <= '0;
            prev_last <= 1'b1;
        end
        else if (line_valid)
        begin
            prev_data <= line_sample.last ? '0 : line_sample.data;
            prev_last <= line_sample.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            filt_valid <= 1'b0;
        end
        else
        begin
            filt_valid <= line_valid;
        end
    end

    // output register, holds the last valid sample between strobes
    always_ff @(posedge clk)
    begin
        if (line_valid)
        begin
            filt_sample.angle <= line_sample.angle;
            filt_sample.s     <= line_sample.s;
            filt_sample.value <= diff;
        end
    end

    // a line is never cut short by a new angle
    a_angle_steady_in_line: assert property (
        @(posedge clk) disable iff (reset_n)
        (line_valid && !prev_last) |-> (line_sample.angle == filt_sample.angle)
    );

endmodule

// ==== hw/sinogram_addresser.sv ====
`timescale 1ns/1ps

module sinogram_addresser
    import nabp_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset_n,
    // host control
    input  logic                               hs_kick,
    // from the line reader
    input  logic [s_length-1:0]                fr_s_val,
    input  logic                               fr_next_angle,
    // to the host
    output logic                               hs_done,
    output logic                               fr_busy,
    // to the line reader
    output logic [angle_length-1:0]            fr_angle,
    output logic                               fr_has_next_angle,
    output logic                               fr_next_angle_ack,
    // to the sinogram RAM
    output logic [sinogram_address_length-1:0] sg_addr
);

    typedef enum logic {
        st_idle,
        st_work
    } state_t;

    state_t state;
    state_t next_state;

    logic [sinogram_address_length-1:0] sg_base_addr;

    assign fr_busy = (state == st_work);

    // more lines to go while below the last angle of the half turn
    assign fr_has_next_angle = (fr_angle < (half_turn - angle_step));

    // mealy outputs, both decoded from the end-of-line strobe
    assign fr_next_angle_ack = fr_busy && fr_next_angle && fr_has_next_angle;
    assign hs_done = fr_busy && fr_next_angle && !fr_has_next_angle;

    // address of the current sample
    assign sg_addr = sg_base_addr + sinogram_address_length'(fr_s_val);

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            st_idle:
            begin
                // a kick while working is dropped here
                if (hs_kick)
                begin
                    next_state = st_work;
                end
            end
            st_work:
            begin
                if (hs_done)
                begin
                    next_state = st_idle;
                end
            end
            default:
            begin
                next_state = st_idle;
            end
        endcase
    end

    // angle and line base, held at zero between runs
    always_ff @(posedge clk)
    begin
        if (reset_n || state == st_idle)
        begin
            fr_angle     <= '0;
            sg_base_addr <= '0;
        end
        else if (fr_next_angle_ack)
        begin
            fr_angle     <= fr_angle + angle_step;
            sg_base_addr <= sg_base_addr + sinogram_address_length'(projection_line_size);
        end
    end

    // the reader only ends lines during a run
    a_next_angle_in_run: assert property (
        @(posedge clk) disable iff (reset_n)
        fr_next_angle |-> fr_busy
    );

endmodule

// ==== hw/sinogram_ram.sv ====
`timescale 1ns/1ps

module sinogram_ram
    import nabp_pkg::*;
(
    input  logic                               clk,
    // host write port
    input  logic                               wr_en,
    input  logic [sinogram_address_length-1:0] wr_addr,
    input  logic [sample_width-1:0]            wr_data,
    // read port, data one cycle after the address
    input  logic [sinogram_address_length-1:0] rd_addr,
    output logic [sample_width-1:0]            rd_data
);

    logic [sample_width-1:0] mem [sinogram_words];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

    // once the addresser has come out of reset the read address stays known
    a_rd_addr_known: assert property (
        @(posedge clk)
        !$isunknown($past(rd_addr)) |-> !$isunknown(rd_addr)
    );

endmodule

// ==== nabp_sinogram.f ====
+incdir+sim
hw/nabp_pkg.sv
hw/sinogram_addresser.sv
hw/sinogram_ram.sv
hw/projection_line_reader.sv
hw/ramp_filter.sv
hw/nabp_sinogram_top.sv
sim/tb_nabp_sinogram.sv

// ==== sim/tb_nabp_model.svh ====
`ifndef TB_NABP_MODEL_SVH
`define TB_NABP_MODEL_SVH

// lines stored angle-major, one line of detector samples per angle
localparam int model_angles = int'(half_turn);
localparam int model_line = projection_line_size;
localparam int model_samples = model_angles * model_line;

// copy of what the host wrote
logic [sample_width-1:0] model_sino [model_samples];

function automatic int line_addr(input int angle, input int s);
    return angle * model_line + s;
endfunction

function automatic void record_write(input int addr, input logic [sample_width-1:0] data);
    model_sino[addr] = data;
endfunction

// position of the n-th filtered sample of a run
function automatic int angle_at(input int n);
    return n / model_line;
endfunction

function automatic int s_at(input int n);
    return n % model_line;
endfunction

// first difference along the line, zero before the first sample
function automatic logic [filt_width-1:0] expected_filt(input int angle, input int s);
    int cur;
    int prev;
    cur = int'(model_sino[line_addr(angle, s)]);
    if (s == 0)
    begin
        prev = 0;
    end
    else
    begin
        prev = int'(model_sino[line_addr(angle, s - 1)]);
    end
    return filt_width'(cur - prev);
endfunction

`endif

// ==== sim/tb_nabp_sinogram.sv ====
`timescale 1ns/1ps

module tb_nabp_sinogram
    import nabp_pkg::*;
();

    // two loads and two runs fit well inside this
    localparam int timeout_cycles = 1000;
    localparam int reset_cycles = 4;
    localparam int mid_kick_delay = 40;

    logic                               clk;
    logic                               reset_n;
    logic                               wr_en;
    logic [sinogram_address_length-1:0] wr_addr;
    logic [sample_width-1:0]            wr_data;
    logic                               hs_kick;
    logic                               hs_done;
    logic                               fr_busy;
    filt_sample_t                       filt_sample;
    logic                               filt_valid;

    int   cycle_cnt = 0;
    int   order_errors = 0;
    int   value_errors = 0;
    int   control_errors = 0;
    int   run_samples = 0;
    int   run_dones = 0;
    int   done_cycle = -1;
    int   last_sample_cycle = -1;
    logic kicked = 1'b0;
    logic done_prev = 1'b0;

    `include "tb_nabp_model.svh"

    nabp_sinogram_top u_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .hs_kick     (hs_kick),
        .hs_done     (hs_done),
        .fr_busy     (fr_busy),
        .filt_sample (filt_sample),
        .filt_valid  (filt_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error_counts();
        $display("errors: order %0d, value %0d, control %0d",
                 order_errors, value_errors, control_errors);
    endtask

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles)
        begin
            $display("timeout after %0d cycles, the filtered stream never completed", cycle_cnt);
            report_error_counts();
            $display("Test failed");
            $finish;
        end
    end

    // compare one filtered sample with the expected stream position
    task automatic check_sample();
        int                    angle;
        int                    s;
        logic [filt_width-1:0] expected;
        if (run_samples >= model_samples)
        begin
            $display("extra filtered sample after the end of the run");
            order_errors++;
        end
        else
        begin
            angle = angle_at(run_samples);
            s = s_at(run_samples);
            expected = expected_filt(angle, s);
            if (filt_sample.angle != angle_length'(angle))
            begin
                $display("mismatch filt_sample.angle: expected %h, actual %h",
                         angle_length'(angle), filt_sample.angle);
                order_errors++;
            end
            if (filt_sample.s != s_length'(s))
            begin
                $display("mismatch filt_sample.s: expected %h, actual %h",
                         s_length'(s), filt_sample.s);
                order_errors++;
            end
            if (filt_sample.value != expected)
            begin
                $display("mismatch filt_sample.value at angle %0d s %0d: expected %h, actual %h",
                         angle, s, expected, filt_sample.value);
                value_errors++;
            end
        end
        run_samples++;
        last_sample_cycle = cycle_cnt;
    endtask

    // outputs are registered or decoded from registers, stable at the falling edge
    always @(negedge clk)
    begin
        // reset_n is active high
        if (!reset_n)
        begin
            if (!kicked && (fr_busy || hs_done || filt_valid))
            begin
                $display("output active before the first kick: busy %b done %b valid %b",
                         fr_busy, hs_done, filt_valid);
                control_errors++;
            end
            if (done_prev && fr_busy)
            begin
                $display("fr_busy still high one cycle after hs_done");
                control_errors++;
            end
            done_prev = hs_done;
            if (hs_done)
            begin
                run_dones++;
                done_cycle = cycle_cnt;
            end
            if (filt_valid)
            begin
                check_sample();
            end
        end
    end

    task automatic load_sinogram();
        logic [sample_width-1:0] data;
        for (int a = 0; a < model_samples; a++)
        begin
            @(negedge clk);
            data = sample_width'($urandom);
            wr_en = 1'b1;
            wr_addr = sinogram_address_length'(a);
            wr_data = data;
            record_write(a, data);
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic run_projection(input logic mid_kick);
        run_samples = 0;
        run_dones = 0;
        done_cycle = -1;
        last_sample_cycle = -1;
        @(negedge clk);
        hs_kick = 1'b1;
        kicked = 1'b1;
        @(negedge clk);
        hs_kick = 1'b0;
        if (mid_kick)
        begin
            // must be dropped while busy
            repeat (mid_kick_delay) @(negedge clk);
            hs_kick = 1'b1;
            @(negedge clk);
            hs_kick = 1'b0;
        end
        while (run_samples < model_samples)
        begin
            @(negedge clk);
        end
        // catch stray samples or done pulses
        repeat (4) @(negedge clk);
        if (run_samples != model_samples)
        begin
            $display("run gave %0d filtered samples instead of %0d", run_samples, model_samples);
            order_errors++;
        end
        if (run_dones != 1)
        begin
            $display("hs_done pulsed %0d times in one run", run_dones);
            control_errors++;
        end
        if (last_sample_cycle != done_cycle + 2)
        begin
            $display("final filtered sample not two cycles after hs_done");
            control_errors++;
        end
        if (fr_busy)
        begin
            $display("fr_busy did not return low after the run");
            control_errors++;
        end
    endtask

    initial
    begin
        void'($urandom(32'h0372cd03));
        reset_n = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        hs_kick = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b0;
        // idle stretch before any load
        repeat (5) @(negedge clk);
        load_sinogram();
        run_projection(1'b1);
        load_sinogram();
        run_projection(1'b0);
        report_error_counts();
        if (order_errors + value_errors + control_errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
